// File: logic/dpa_pkg.sv
`default_nettype none

package dpa_pkg;

  //////////////////////////////////////////////////
  // Widths and geometry
  //////////////////////////////////////////////////
  localparam int ADDR_W      = 20;
  localparam int PIXEL_W     = 24;    // Packed RGB
  localparam int GLYPH_W     = 13;    // Also the ROM word width
  localparam int GLYPH_H     = 24;
  localparam int GLYPH_COUNT = 8;     // HH:MM:SS
  localparam int COLON_GLYPH = 10;
  localparam int CR_A_W      = 9;
  localparam int IMG_SIDE    = 256;

  // Top-left pixel of the clock at row 232 and column 151
  localparam int CLOCK_ORIGIN = 232 * IMG_SIDE + 151;

  localparam int DISPLAY_TICKS       = 2;
  localparam int TICK_CYCLES_DEFAULT = 1000000;

  typedef logic [PIXEL_W-1:0] pixel_t;
  typedef logic [ADDR_W-1:0]  addr_t;

  typedef struct packed {
    logic [3:0] h1;
    logic [3:0] h0;
    logic [3:0] m1;
    logic [3:0] m0;
    logic [3:0] s1;
    logic [3:0] s0;
  } bcd_time_t;

  //////////////////////////////////////////////////
  // Header layout
  //////////////////////////////////////////////////
  localparam addr_t HDR_TIME   = addr_t'(0);   // hh:mm:ss in binary bytes
  localparam addr_t HDR_FB     = addr_t'(1);
  localparam addr_t HDR_COUNT  = addr_t'(2);
  localparam addr_t HDR_PHOTO0 = addr_t'(3);   // One word per photo

endpackage

`default_nettype wire

// File: logic/time_keeper.sv
`timescale 1ns/1ns
`default_nettype none

module time_keeper #(
  parameter int TICK_CYCLES = dpa_pkg::TICK_CYCLES_DEFAULT
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         time_load,
  input  wire [dpa_pkg::PIXEL_W-1:0]  load_time,
  output logic                        tick,
  output dpa_pkg::bcd_time_t          digits
);

  logic [31:0]        cyc_cnt;
  dpa_pkg::bcd_time_t next_sec;

  function automatic logic [7:0] to_bcd(input logic [7:0] bin);
    logic [7:0] tens;
    logic [7:0] ones;
    tens = bin / 8'd10;
    ones = bin % 8'd10;
    return {tens[3:0], ones[3:0]};
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cyc_cnt <= 32'd0;
      tick    <= 1'b0;
    end else if (cyc_cnt == 32'(TICK_CYCLES - 1)) begin
      cyc_cnt <= 32'd0;
      tick    <= 1'b1;
    end else begin
      cyc_cnt <= cyc_cnt + 32'd1;
      tick    <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // BCD increment with rollover
  //////////////////////////////////////////////////
  always_comb begin
    next_sec = digits;
    if (digits.s0 != 4'd9) begin
      next_sec.s0 = digits.s0 + 4'd1;
    end else begin
      next_sec.s0 = 4'd0;
      if (digits.s1 != 4'd5) begin
        next_sec.s1 = digits.s1 + 4'd1;
      end else begin
        next_sec.s1 = 4'd0;
        if (digits.m0 != 4'd9) begin
          next_sec.m0 = digits.m0 + 4'd1;
        end else begin
          next_sec.m0 = 4'd0;
          if (digits.m1 != 4'd5) begin
            next_sec.m1 = digits.m1 + 4'd1;
          end else begin
            next_sec.m1 = 4'd0;
            if (digits.h1 == 4'd2 && digits.h0 == 4'd3) begin
              next_sec.h1 = 4'd0;             // Midnight
              next_sec.h0 = 4'd0;
            end else if (digits.h0 == 4'd9) begin
              next_sec.h1 = digits.h1 + 4'd1;
              next_sec.h0 = 4'd0;
            end else begin
              next_sec.h0 = digits.h0 + 4'd1;
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      digits <= '0;
    end else if (time_load) begin
      digits <= {to_bcd(load_time[23:16]), to_bcd(load_time[15:8]), to_bcd(load_time[7:0])};
    end else if (tick) begin
      digits <= next_sec;
    end
  end

endmodule

`default_nettype wire

// File: logic/photo_copier.sv
`timescale 1ns/1ns
`default_nettype none

module photo_copier (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  copy_start,
  input  wire dpa_pkg::addr_t  copy_src,
  input  wire dpa_pkg::addr_t  fb_base,
  input  wire dpa_pkg::pixel_t im_q,
  output logic                 copy_req,
  output dpa_pkg::addr_t       copy_a,
  output dpa_pkg::pixel_t      copy_d,
  output logic                 copy_wen,
  output logic                 copy_done
);

  logic        busy;
  logic [1:0]  phase;     // Read, wait, write
  logic [15:0] index;     // Pixel index within the photo
  logic        write_phase;
  logic        last_pixel;

  assign write_phase = (phase == 2'd2);
  assign last_pixel  = (index == 16'(dpa_pkg::IMG_SIDE * dpa_pkg::IMG_SIDE - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy  <= 1'b0;
      phase <= 2'd0;
      index <= 16'd0;
    end else if (copy_start && !busy) begin
      busy  <= 1'b1;
      phase <= 2'd0;
      index <= 16'd0;
    end else if (busy) begin
      if (write_phase) begin
        phase <= 2'd0;
        index <= index + 16'd1;
        if (last_pixel) busy <= 1'b0;
      end else begin
        phase <= phase + 2'd1;
      end
    end
  end

  // Source address while reading, frame address on the write
  always_comb begin
    if (write_phase) begin
      copy_a = fb_base + dpa_pkg::addr_t'(index);
    end else begin
      copy_a = copy_src + dpa_pkg::addr_t'(index);
    end
  end

  assign copy_req  = busy;
  assign copy_d    = im_q;        // Valid two cycles after the read
  assign copy_wen  = ~(busy & write_phase);
  assign copy_done = busy & write_phase & last_pixel;

endmodule

`default_nettype wire

// File: logic/clock_overlay.sv
`timescale 1ns/1ns
`default_nettype none

module clock_overlay (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         overlay_start,
  input  wire dpa_pkg::addr_t         fb_base,
  input  wire dpa_pkg::bcd_time_t     digits,
  output logic [dpa_pkg::CR_A_W-1:0]  cr_a,
  input  wire [dpa_pkg::GLYPH_W-1:0]  cr_q,
  output logic                        ovl_req,
  output dpa_pkg::addr_t              ovl_a,
  output dpa_pkg::pixel_t             ovl_d,
  output logic                        ovl_wen,
  output logic                        overlay_done
);

  logic               busy;
  logic [2:0]         glyph;
  logic [4:0]         row;
  logic [3:0]         step;         // 0 ROM address, 1 ROM wait, then columns
  logic [3:0]         col;
  logic [3:0]         glyph_code;
  logic               step_last;
  logic               row_last;
  logic               glyph_last;
  logic               pix_on;
  dpa_pkg::addr_t     rom_line;
  dpa_pkg::bcd_time_t digits_q;

  assign col        = step - 4'd2;
  assign step_last  = (step == 4'(dpa_pkg::GLYPH_W + 1));
  assign row_last   = (row == 5'(dpa_pkg::GLYPH_H - 1));
  assign glyph_last = (glyph == 3'(dpa_pkg::GLYPH_COUNT - 1));

  always_comb begin
    case (glyph)
      3'd0:    glyph_code = digits_q.h1;
      3'd1:    glyph_code = digits_q.h0;
      3'd3:    glyph_code = digits_q.m1;
      3'd4:    glyph_code = digits_q.m0;
      3'd6:    glyph_code = digits_q.s1;
      3'd7:    glyph_code = digits_q.s0;
      default: glyph_code = 4'(dpa_pkg::COLON_GLYPH);   // Positions 2 and 5
    endcase
  end

  assign rom_line = dpa_pkg::addr_t'(dpa_pkg::GLYPH_H) * dpa_pkg::addr_t'(glyph_code)
                  + dpa_pkg::addr_t'(row);

  //////////////////////////////////////////////////
  // Glyph walk
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy  <= 1'b0;
      glyph <= 3'd0;
      row   <= 5'd0;
      step  <= 4'd0;
      cr_a  <= '0;
    end else if (overlay_start && !busy) begin
      busy  <= 1'b1;
      glyph <= 3'd0;
      row   <= 5'd0;
      step  <= 4'd0;
    end else if (busy) begin
      if (step == 4'd0) cr_a <= rom_line[dpa_pkg::CR_A_W-1:0];
      if (step_last) begin
        step <= 4'd0;
        if (row_last) begin
          row <= 5'd0;
          if (glyph_last) busy <= 1'b0;
          else glyph <= glyph + 3'd1;
        end else begin
          row <= row + 5'd1;
        end
      end else begin
        step <= step + 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (overlay_start && !busy) digits_q <= digits;   // Time frozen for the pass
  end

  // MSB of the ROM word is the leftmost column
  assign pix_on = (step >= 4'd2) && cr_q[4'(dpa_pkg::GLYPH_W - 1) - col];

  assign ovl_a = fb_base + dpa_pkg::addr_t'(dpa_pkg::CLOCK_ORIGIN)
               + dpa_pkg::addr_t'(dpa_pkg::IMG_SIDE) * dpa_pkg::addr_t'(row)
               + dpa_pkg::addr_t'(dpa_pkg::GLYPH_W) * dpa_pkg::addr_t'(glyph)
               + dpa_pkg::addr_t'(col);

  assign ovl_req      = busy;
  assign ovl_wen      = ~(busy && step >= 4'd2);
  assign ovl_d        = pix_on ? '1 : '0;
  assign overlay_done = busy & step_last & row_last & glyph_last;

endmodule

`default_nettype wire

// File: logic/dpa_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dpa_ctrl (
  input  wire                         clk,
  input  wire                         reset,
  input  wire dpa_pkg::pixel_t        im_q,
  output dpa_pkg::addr_t              im_a,
  output dpa_pkg::pixel_t             im_d,
  output logic                        im_wen,
  output logic                        copy_start,
  output dpa_pkg::addr_t              copy_src,
  output dpa_pkg::addr_t              fb_base,
  input  wire                         copy_done,
  input  wire                         copy_req,
  input  wire dpa_pkg::addr_t         copy_a,
  input  wire dpa_pkg::pixel_t        copy_d,
  input  wire                         copy_wen,
  output logic                        overlay_start,
  input  wire                         overlay_done,
  input  wire                         ovl_req,
  input  wire dpa_pkg::addr_t         ovl_a,
  input  wire dpa_pkg::pixel_t        ovl_d,
  input  wire                         ovl_wen,
  input  wire                         tick,
  output logic                        time_load,
  output logic [dpa_pkg::PIXEL_W-1:0] load_time
);

  typedef enum logic [2:0] {S_HDR, S_ADDR, S_COPY, S_OVL, S_WAIT} state_t;

  state_t         state;
  logic [1:0]     phase;          // Issue, wait, capture
  dpa_pkg::addr_t hdr_a;
  dpa_pkg::addr_t photo_idx;
  dpa_pkg::addr_t photo_cnt;
  dpa_pkg::addr_t ctrl_a;
  logic [3:0]     shown;          // Ticks spent on the current photo
  logic           tick_pending;
  logic           tick_seen;
  logic           capture;

  assign ctrl_a    = (state == S_ADDR) ? dpa_pkg::HDR_PHOTO0 + photo_idx : hdr_a;
  assign tick_seen = tick | tick_pending;
  assign capture   = (phase == 2'd2);

  //////////////////////////////////////////////////
  // Album sequencer
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state         <= S_HDR;
      phase         <= 2'd0;
      hdr_a         <= dpa_pkg::HDR_TIME;
      photo_idx     <= '0;
      photo_cnt     <= '0;
      shown         <= 4'd0;
      tick_pending  <= 1'b0;
      copy_start    <= 1'b0;
      overlay_start <= 1'b0;
      time_load     <= 1'b0;
    end else begin
      copy_start    <= 1'b0;
      overlay_start <= 1'b0;
      time_load     <= 1'b0;
      if (tick && state != S_WAIT) begin
        tick_pending <= 1'b1;     // Served once the datapath is idle
      end
      case (state)
        S_HDR: begin
          phase <= capture ? 2'd0 : phase + 2'd1;
          if (capture) begin
            hdr_a     <= hdr_a + 1'b1;
            time_load <= (hdr_a == dpa_pkg::HDR_TIME);
            if (hdr_a == dpa_pkg::HDR_COUNT) begin
              photo_cnt <= im_q[dpa_pkg::ADDR_W-1:0];
              state     <= S_ADDR;
            end
          end
        end
        S_ADDR: begin
          phase <= capture ? 2'd0 : phase + 2'd1;
          if (capture) begin
            copy_start <= 1'b1;
            state      <= S_COPY;
          end
        end
        S_COPY: begin
          if (copy_done) begin
            overlay_start <= 1'b1;
            state         <= S_OVL;
          end
        end
        S_OVL: begin
          if (overlay_done) state <= S_WAIT;
        end
        S_WAIT: begin
          if (tick_seen) begin
            tick_pending <= 1'b0;
            if (shown == 4'(dpa_pkg::DISPLAY_TICKS - 1)) begin
              shown     <= 4'd0;
              photo_idx <= (photo_idx == photo_cnt - 1'b1) ? '0 : photo_idx + 1'b1;
              state     <= S_ADDR;
            end else begin
              shown         <= shown + 4'd1;
              overlay_start <= 1'b1;  // Redraw with the new time
              state         <= S_OVL;
            end
          end
        end
        default: state <= S_HDR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_HDR && capture) begin
      if (hdr_a == dpa_pkg::HDR_TIME) load_time <= im_q;
      if (hdr_a == dpa_pkg::HDR_FB) fb_base <= im_q[dpa_pkg::ADDR_W-1:0];
    end
    if (state == S_ADDR && capture) begin
      copy_src <= im_q[dpa_pkg::ADDR_W-1:0];
    end
  end

  //////////////////////////////////////////////////
  // Memory port mux
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      im_a   <= '0;
      im_wen <= 1'b1;
    end else if (copy_req) begin
      im_a   <= copy_a;
      im_wen <= copy_wen;
    end else if (ovl_req) begin
      im_a   <= ovl_a;
      im_wen <= ovl_wen;
    end else begin
      im_a   <= ctrl_a;             // Header reads only
      im_wen <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (copy_req) im_d <= copy_d;
    else if (ovl_req) im_d <= ovl_d;
  end

endmodule

`default_nettype wire

// File: logic/dpa_top.sv
`timescale 1ns/1ns
`default_nettype none

module dpa_top #(
  parameter int TICK_CYCLES = dpa_pkg::TICK_CYCLES_DEFAULT
) (
  input  wire                         clk,
  input  wire                         reset,
  output dpa_pkg::addr_t              im_a,
  input  wire dpa_pkg::pixel_t        im_q,
  output dpa_pkg::pixel_t             im_d,
  output logic                        im_wen,
  output logic [dpa_pkg::CR_A_W-1:0]  cr_a,
  input  wire [dpa_pkg::GLYPH_W-1:0]  cr_q
);

  logic                        copy_start;
  logic                        copy_done;
  dpa_pkg::addr_t              copy_src;
  dpa_pkg::addr_t              fb_base;
  logic                        copy_req;
  dpa_pkg::addr_t              copy_a;
  dpa_pkg::pixel_t             copy_d;
  logic                        copy_wen;

  logic                        overlay_start;
  logic                        overlay_done;
  logic                        ovl_req;
  dpa_pkg::addr_t              ovl_a;
  dpa_pkg::pixel_t             ovl_d;
  logic                        ovl_wen;

  logic                        tick;
  logic                        time_load;
  logic [dpa_pkg::PIXEL_W-1:0] load_time;
  dpa_pkg::bcd_time_t          digits;

  dpa_ctrl i_ctrl (
    .clk          (clk),
    .reset        (reset),
    .im_q         (im_q),
    .im_a         (im_a),
    .im_d         (im_d),
    .im_wen       (im_wen),
    .copy_start   (copy_start),
    .copy_src     (copy_src),
    .fb_base      (fb_base),
    .copy_done    (copy_done),
    .copy_req     (copy_req),
    .copy_a       (copy_a),
    .copy_d       (copy_d),
    .copy_wen     (copy_wen),
    .overlay_start(overlay_start),
    .overlay_done (overlay_done),
    .ovl_req      (ovl_req),
    .ovl_a        (ovl_a),
    .ovl_d        (ovl_d),
    .ovl_wen      (ovl_wen),
    .tick         (tick),
    .time_load    (time_load),
    .load_time    (load_time)
  );

  photo_copier i_copier (
    .clk       (clk),
    .reset     (reset),
    .copy_start(copy_start),
    .copy_src  (copy_src),
    .fb_base   (fb_base),
    .im_q      (im_q),
    .copy_req  (copy_req),
    .copy_a    (copy_a),
    .copy_d    (copy_d),
    .copy_wen  (copy_wen),
    .copy_done (copy_done)
  );

  clock_overlay i_overlay (
    .clk          (clk),
    .reset        (reset),
    .overlay_start(overlay_start),
    .fb_base      (fb_base),
    .digits       (digits),
    .cr_a         (cr_a),
    .cr_q         (cr_q),
    .ovl_req      (ovl_req),
    .ovl_a        (ovl_a),
    .ovl_d        (ovl_d),
    .ovl_wen      (ovl_wen),
    .overlay_done (overlay_done)
  );

  time_keeper #(
    .TICK_CYCLES(TICK_CYCLES)
  ) i_time (
    .clk      (clk),
    .reset    (reset),
    .time_load(time_load),
    .load_time(load_time),
    .tick     (tick),
    .digits   (digits)
  );

endmodule

`default_nettype wire

// File: bench/dpa_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module dpa_assertions (
  input wire                         clk,
  input wire                         reset,
  input wire                         im_wen,
  input wire dpa_pkg::addr_t         im_a,
  input wire dpa_pkg::addr_t         fb_base,
  input wire                         copy_start,
  input wire                         overlay_start,
  input wire [dpa_pkg::CR_A_W-1:0]   cr_a
);

  logic [dpa_pkg::ADDR_W:0] fb_end;

  assign fb_end = {1'b0, fb_base} + (dpa_pkg::ADDR_W+1)'(dpa_pkg::IMG_SIDE * dpa_pkg::IMG_SIDE);

  a_write_in_frame: assert property (@(posedge clk) disable iff (reset)
    !im_wen |-> (im_a >= fb_base && {1'b0, im_a} < fb_end))
    else $error("write outside the frame buffer");

  a_start_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(copy_start && overlay_start))
    else $error("copy_start and overlay_start together");

  a_rom_range: assert property (@(posedge clk) disable iff (reset)
    cr_a < dpa_pkg::CR_A_W'(264))
    else $error("character ROM address out of range");

endmodule

bind dpa_top dpa_assertions i_assertions (
  .clk          (clk),
  .reset        (reset),
  .im_wen       (im_wen),
  .im_a         (im_a),
  .fb_base      (fb_base),
  .copy_start   (copy_start),
  .overlay_start(overlay_start),
  .cr_a         (cr_a)
);

`default_nettype wire

// File: bench/dpa_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dpa_tb;

  localparam int     TICK_CYCLES = 250000;
  localparam int     ROWS        = 2;
  localparam int     MAX_PASSES  = 5;
  localparam int     NPIX        = dpa_pkg::IMG_SIDE * dpa_pkg::IMG_SIDE;
  localparam int     OVL_WRITES  = dpa_pkg::GLYPH_COUNT * dpa_pkg::GLYPH_H * dpa_pkg::GLYPH_W;
  localparam longint WATCHDOG_NS = longint'(ROWS) * MAX_PASSES * TICK_CYCLES * 100 * 3 / 2;

  logic                         clk;
  logic                         reset;
  dpa_pkg::addr_t               im_a;
  dpa_pkg::pixel_t              im_q;
  dpa_pkg::pixel_t              im_d;
  logic                         im_wen;
  logic [dpa_pkg::CR_A_W-1:0]   cr_a;
  logic [dpa_pkg::GLYPH_W-1:0]  cr_q;

  dpa_pkg::pixel_t              mem [0:(1 << dpa_pkg::ADDR_W)-1];
  logic [dpa_pkg::GLYPH_W-1:0]  rom [0:263];
  logic [31:0]                  lfsr;

  // Stimulus table with one row per run
  logic [23:0]    tbl_time   [ROWS];
  int             tbl_count  [ROWS];
  dpa_pkg::addr_t tbl_fb     [ROWS];
  dpa_pkg::addr_t tbl_photo  [ROWS][2];
  int             tbl_passes [ROWS];

  int             errors;
  int             writes;
  int             row;
  logic           checking;
  logic           row_done;
  logic           in_copy;
  int             idx;
  int             pass;
  int             start_secs;
  dpa_pkg::addr_t cur_src;

  dpa_top #(.TICK_CYCLES(TICK_CYCLES)) i_dut (
    .clk   (clk),
    .reset (reset),
    .im_a  (im_a),
    .im_q  (im_q),
    .im_d  (im_d),
    .im_wen(im_wen),
    .cr_a  (cr_a),
    .cr_q  (cr_q)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1
  endfunction

  // Glyph index for position k of HH:MM:SS
  function automatic int glyph_of(input int secs, input int k);
    int h;
    int m;
    int s;
    h = secs / 3600;
    m = (secs / 60) % 60;
    s = secs % 60;
    case (k)
      0:       return h / 10;
      1:       return h % 10;
      3:       return m / 10;
      4:       return m % 10;
      6:       return s / 10;
      7:       return s % 10;
      default: return dpa_pkg::COLON_GLYPH;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Expected write stream
  //////////////////////////////////////////////////
  task automatic check_write();
    dpa_pkg::addr_t  ea;
    dpa_pkg::pixel_t ed;
    logic [12:0]     bits;
    int              k;
    int              r;
    int              c;
    int              secs;
    if (in_copy) begin
      ea = tbl_fb[row] + dpa_pkg::addr_t'(idx);
      ed = mem[cur_src + dpa_pkg::addr_t'(idx)];
    end else begin
      k = idx / (dpa_pkg::GLYPH_H * dpa_pkg::GLYPH_W);
      r = (idx / dpa_pkg::GLYPH_W) % dpa_pkg::GLYPH_H;
      c = idx % dpa_pkg::GLYPH_W;
      secs = (start_secs + pass) % 86400;
      bits = rom[dpa_pkg::GLYPH_H * glyph_of(secs, k) + r];
      ed = bits[12 - c] ? '1 : '0;
      ea = tbl_fb[row] + dpa_pkg::addr_t'(dpa_pkg::CLOCK_ORIGIN + dpa_pkg::IMG_SIDE * r
           + dpa_pkg::GLYPH_W * k + c);
    end
    writes++;
    if (im_a !== ea) begin
      errors++;
      $display("Error at %0t: im_a = %h, expected %h", $time, im_a, ea);
    end else if (im_d !== ed) begin
      errors++;
      $display("Error at %0t: im_d = %h, expected %h", $time, im_d, ed);
    end
    idx++;
    if (in_copy && idx == NPIX) begin
      in_copy = 1'b0;
      idx     = 0;
    end else if (!in_copy && idx == OVL_WRITES) begin
      idx  = 0;
      pass++;
      if (pass == tbl_passes[row]) begin
        checking = 1'b0;
        row_done = 1'b1;
      end else if (pass % dpa_pkg::DISPLAY_TICKS == 0) begin
        in_copy = 1'b1;                 // Next photo, wrapping
        cur_src = tbl_photo[row][(pass / dpa_pkg::DISPLAY_TICKS) % tbl_count[row]];
      end
    end
  endtask

  // Memory and ROM models and the write monitor
  always @(posedge clk) begin
    if (!im_wen) mem[im_a] <= im_d;
    else im_q <= mem[im_a];
    cr_q <= rom[cr_a];
    if (reset && im_wen !== 1'b1) begin
      errors++;
      $display("Error at %0t: im_wen = %b during reset, expected 1", $time, im_wen);
    end
    if (!reset && checking && !im_wen) check_write();
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout, the run did not finish in %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    im_q     = '0;
    cr_q     = '0;
    errors   = 0;
    writes   = 0;
    checking = 1'b0;
    row_done = 1'b0;
    lfsr     = 32'd79486;

    tbl_time[0] = {8'd12, 8'd34, 8'd56};
    tbl_count[0] = 2;
    tbl_fb[0] = 20'h80000;
    tbl_photo[0][0] = 20'h10000;
    tbl_photo[0][1] = 20'h20000;
    tbl_passes[0] = 5;                  // Third copy is photo 0 again
    tbl_time[1] = {8'd23, 8'd59, 8'd58};
    tbl_count[1] = 1;
    tbl_fb[1] = 20'h40000;
    tbl_photo[1][0] = 20'h30000;
    tbl_photo[1][1] = 20'h30000;
    tbl_passes[1] = 3;                  // Midnight rollover

    for (int a = 0; a < (1 << dpa_pkg::ADDR_W); a++) begin
      mem[a] = {4'h5, 20'(a)};
    end
    for (int p = 1; p <= 3; p++) begin
      for (int i = 0; i < NPIX; i++) begin
        for (int b = 0; b < dpa_pkg::PIXEL_W; b++) begin
          lfsr = lfsr_step(lfsr);
          mem[(p << 16) + i][b] = lfsr[0];
        end
      end
    end
    for (int g = 0; g < 264; g++) begin
      for (int b = 0; b < dpa_pkg::GLYPH_W; b++) begin
        lfsr = lfsr_step(lfsr);
        rom[g][b] = lfsr[0];
      end
    end

    ////////////////////////////////////////////////
    // Table loop
    ////////////////////////////////////////////////
    for (int i = 0; i < ROWS; i++) begin
      @(negedge clk);
      reset = 1'b1;
      row = i;
      mem[dpa_pkg::HDR_TIME] = tbl_time[i];
      mem[dpa_pkg::HDR_FB] = {4'h0, tbl_fb[i]};
      mem[dpa_pkg::HDR_COUNT] = 24'(tbl_count[i]);
      for (int p = 0; p < tbl_count[i]; p++) begin
        mem[dpa_pkg::HDR_PHOTO0 + dpa_pkg::addr_t'(p)] = {4'h0, tbl_photo[i][p]};
      end
      start_secs = tbl_time[i][23:16] * 3600 + tbl_time[i][15:8] * 60 + tbl_time[i][7:0];
      pass     = 0;
      idx      = 0;
      in_copy  = 1'b1;
      cur_src  = tbl_photo[i][0];
      row_done = 1'b0;
      checking = 1'b1;
      repeat (16) @(negedge clk);
      reset = 1'b0;
      wait (row_done);
    end

    $display("Errors: %0d, writes checked: %0d", errors, writes);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
logic/dpa_pkg.sv
logic/time_keeper.sv
logic/photo_copier.sv
logic/clock_overlay.sv
logic/dpa_ctrl.sv
logic/dpa_top.sv
bench/dpa_assertions.sv
bench/dpa_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= dpa_tb
FILELIST  ?= all.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
